/* verif/armCoreTestdata.txt */
# Each test: name, program word count, commit count, then the program words in hex,
# then the expected commits in program order as register and value pairs in hex
resetIdle 0 0
immediateOps 11 11
E3A010FF E3A022FF E2813C01 E241400F E2615B01 E20260FF
E38174AB E2228055 E3C2920F E3E0A012 E3A0BFFF
1 000000FF 2 F000000F 3 000001FF 4 000000F0 5 00000301 6 0000000F
7 AB0000FF 8 F000005A 9 0000000F a FFFFFFED b 000003FC
dependentChain 10 10
E3A00005 E2801003 E2412001 E2623020 E3834C01 E22450FF E20560F0
E3C67020 E0878006 E0889008
0 00000005 1 00000008 2 00000007 3 00000019 4 00000119 5 000001E6
6 000000E0 7 000000C0 8 000001A0 9 00000340
registerShifts 13 13
E3A01102 E38120F1 E1A03202 E1A04422 E1A05442 E1A06262 E1A07002
E1A08022 E1A09042 E1A0A062 E081B082 E042CFA1 E022D1C1
1 80000000 2 800000F1 3 00000F10 4 00800000 5 FF800000 6 1800000F
7 800000F1 8 00000000 9 FFFFFFFF a 800000F1 b 800001E2 c 800000F0 d 700000F1
fillAndOverride 14 14
E3A00001 E2800001 E2800001 E2800001 E2800001 E2800001 E2800001
E2800001 E3A01011 E3A02022 E3A03033 E3A04044 E3A01055 E0805001
0 00000001 0 00000002 0 00000003 0 00000004 0 00000005 0 00000006 0 00000007
0 00000008 1 00000011 2 00000022 3 00000033 4 00000044 1 00000055 5 0000005D

/* files.f */
design/armCorePkg.sv
design/decodeStage.sv
design/registerStatusFile.sv
design/reorderBuffer.sv
design/reservationStation.sv
design/executeUnit.sv
design/armCore.sv
verif/armCoreTb.sv

/* runSim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module armCoreTb -o armCoreSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/armCoreSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation completed successfully" sim.log; then
    exit 0
fi
exit 1

/* verif/armCoreTb.sv */
`timescale 1ns/100ps
`default_nettype none

module armCoreTb import armCorePkg::*; ();

    logic                    clk;
    logic                    arstN;
    logic [dataWidth-1:0]    pc;
    logic [dataWidth-1:0]    instr;
    logic                    commitValid;
    logic [regAddrWidth-1:0] commitReg;
    logic [dataWidth-1:0]    commitData;

    logic [dataWidth-1:0]    progMem [64];
    int                      progLen = 0;
    logic [regAddrWidth-1:0] expReg  [64];
    logic [dataWidth-1:0]    expData [64];
    int                      expLen = 0;

    int testCount  = 0;
    int testFails  = 0;
    int checkFails = 0;

    armCore UUT (
        .clk(clk), .arstN(arstN), .pc(pc), .instr(instr),
        .commitValid(commitValid), .commitReg(commitReg), .commitData(commitData)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Past the program end the fetch sees a class 01 word, which decode drops
    assign instr = (pc[dataWidth-1:2] < 30'(progLen)) ? progMem[pc[7:2]] : 32'hE4000000;

    //////////////////////////////////////////////////////////////////////
    // Test sequencing

    // Wait up to 2000 cycles for the next retired instruction
    task automatic waitCommit(output bit seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < 2000) begin
            @(negedge clk);
            cycles++;
            seen = commitValid;
        end
    endtask

    task automatic runTest(input string name);
        bit seen;
        int idx;
        int failsBefore;
        failsBefore = checkFails;
        arstN = 1'b0;
        repeat (4) @(negedge clk);
        if (pc !== '0 || commitValid !== 1'b0) begin
            $display("CHECK FAILED at %0t: %s reset state pc %h commitValid %b",
                     $time, name, pc, commitValid);
            checkFails++;
        end
        arstN = 1'b1;
        idx   = 0;
        seen  = 1'b1;
        while (seen && idx < expLen) begin
            waitCommit(seen);
            if (!seen) begin
                $display("Timeout at %0t: test %s never retired commit %0d of %0d",
                         $time, name, idx + 1, expLen);
                checkFails++;
            end else begin
                if (commitReg !== expReg[idx] || commitData !== expData[idx]) begin
                    $display("CHECK FAILED at %0t: %s commit %0d wrote r%0d = %h, expected r%0d = %h",
                             $time, name, idx + 1, commitReg, commitData,
                             expReg[idx], expData[idx]);
                    checkFails++;
                end
                idx++;
            end
        end
        // Nothing else may retire once the list is done
        repeat (20) begin
            @(negedge clk);
            if (commitValid !== 1'b0) begin
                $display("CHECK FAILED at %0t: %s unexpected commit r%0d = %h",
                         $time, name, commitReg, commitData);
                checkFails++;
            end
        end
        testCount++;
        if (checkFails == failsBefore) begin
            $display("Test %s passed, %0d commits checked", name, expLen);
        end else begin
            testFails++;
            $display("Test %s FAILED with %0d errors", name, checkFails - failsBefore);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test data reader
    initial begin
        int                      fd;
        int                      code;
        int                      nWords;
        int                      nCommits;
        logic [8*32-1:0]         token;
        logic [8*120-1:0]        restOfLine;
        logic [dataWidth-1:0]    word;
        logic [regAddrWidth-1:0] regIdx;
        arstN = 1'b0;
        fd = $fopen("verif/armCoreTestdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file verif/armCoreTestdata.txt");
            checkFails++;
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", token);
                if (code == 1 && string'(token) == "#") begin
                    code = $fgets(restOfLine, fd);
                end else if (code == 1) begin
                    code = $fscanf(fd, "%d %d", nWords, nCommits);
                    if (nWords > 64 || nCommits > 64) begin
                        $display("Test %s is longer than the 64 entries the memory holds",
                                 string'(token));
                        checkFails++;
                        break;
                    end
                    arstN = 1'b0;
                    for (int i = 0; i < nWords; i++) begin
                        code = $fscanf(fd, "%h", word);
                        progMem[i] = word;
                    end
                    for (int i = 0; i < nCommits; i++) begin
                        code = $fscanf(fd, "%h %h", regIdx, word);
                        expReg[i]  = regIdx;
                        expData[i] = word;
                    end
                    progLen = nWords;
                    expLen  = nCommits;
                    runTest(string'(token));
                end
            end
            $fclose(fd);
        end
        $display("Tests run %0d, tests failed %0d, checks failed %0d",
                 testCount, testFails, checkFails);
        if (checkFails == 0 && testCount > 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/armCore.sv */
`timescale 1ns/100ps
`default_nettype none

module armCore import armCorePkg::*; (
    input  logic                    clk,
    input  logic                    arstN,
    output logic [dataWidth-1:0]    pc,
    input  logic [dataWidth-1:0]    instr,
    output logic                    commitValid,
    output logic [regAddrWidth-1:0] commitReg,
    output logic [dataWidth-1:0]    commitData
);

    logic                    stall, issue, issueValid, useImm, needA;
    logic [3:0]              op;
    logic [regAddrWidth-1:0] rn, rm, rd;
    logic [dataWidth-1:0]    imm;
    logic [4:0]              shamt;
    logic [1:0]              shType;

    logic [dataWidth-1:0]    regAValue, regBValue, robAData, robBData;
    logic                    regABusy, regBBusy, robADone, robBDone;
    logic [robTagWidth-1:0]  srcATag, srcBTag, tail, commitTag;
    logic                    robFull, rsFull, cdbAHit, cdbBHit;
    logic                    srcAReady, srcBReady;
    logic [dataWidth-1:0]    srcAValue, srcBValue;

    logic                    cdbValid;
    logic [robTagWidth-1:0]  cdbTag;
    logic [dataWidth-1:0]    cdbData;

    logic                    dispatchValid, dispatchUseImm;
    logic [3:0]              dispatchOp;
    logic [robTagWidth-1:0]  dispatchTag;
    logic [dataWidth-1:0]    dispatchA, dispatchB, dispatchImm;
    logic [4:0]              dispatchShamt;
    logic [1:0]              dispatchShType;

    assign stall = robFull | rsFull;
    assign issue = issueValid & ~stall;

    //////////////////////////////////////////////////////////////////////
    // Operand lookup at issue
    // MOV and MVN ignore Rn
    assign needA   = (op != opMov) && (op != opMvn);
    assign cdbAHit = cdbValid && (cdbTag == srcATag);
    assign cdbBHit = cdbValid && (cdbTag == srcBTag);

    assign srcAReady = !needA || !regABusy || robADone || cdbAHit;
    assign srcBReady = useImm || !regBBusy || robBDone || cdbBHit;
    assign srcAValue = !regABusy ? regAValue : (robADone ? robAData : cdbData);
    assign srcBValue = !regBBusy ? regBValue : (robBDone ? robBData : cdbData);

    decodeStage decode (
        .clk(clk), .arstN(arstN), .stall(stall), .pc(pc), .instr(instr),
        .issueValid(issueValid), .op(op), .rn(rn), .rm(rm), .rd(rd),
        .useImm(useImm), .imm(imm), .shamt(shamt), .shType(shType)
    );

    registerStatusFile regStatus (
        .clk(clk), .arstN(arstN), .rn(rn), .rm(rm),
        .srcAValue(regAValue), .srcABusy(regABusy), .srcATag(srcATag),
        .srcBValue(regBValue), .srcBBusy(regBBusy), .srcBTag(srcBTag),
        .issue(issue), .rd(rd), .issueTag(tail),
        .commitValid(commitValid), .commitReg(commitReg),
        .commitData(commitData), .commitTag(commitTag)
    );

    reorderBuffer rob (
        .clk(clk), .arstN(arstN), .issue(issue), .issueReg(rd),
        .tail(tail), .full(robFull),
        .queryATag(srcATag), .queryADone(robADone), .queryAData(robAData),
        .queryBTag(srcBTag), .queryBDone(robBDone), .queryBData(robBData),
        .cdbValid(cdbValid), .cdbTag(cdbTag), .cdbData(cdbData),
        .commitValid(commitValid), .commitReg(commitReg),
        .commitData(commitData), .commitTag(commitTag)
    );

    reservationStation station (
        .clk(clk), .arstN(arstN), .issue(issue), .op(op), .robTag(tail),
        .srcAReady(srcAReady), .srcAValue(srcAValue), .srcATag(srcATag),
        .srcBReady(srcBReady), .srcBValue(srcBValue), .srcBTag(srcBTag),
        .useImm(useImm), .imm(imm), .shamt(shamt), .shType(shType),
        .full(rsFull), .cdbValid(cdbValid), .cdbTag(cdbTag), .cdbData(cdbData),
        .dispatchValid(dispatchValid), .dispatchOp(dispatchOp),
        .dispatchTag(dispatchTag), .dispatchA(dispatchA), .dispatchB(dispatchB),
        .dispatchUseImm(dispatchUseImm), .dispatchImm(dispatchImm),
        .dispatchShamt(dispatchShamt), .dispatchShType(dispatchShType)
    );

    executeUnit execute (
        .clk(clk), .arstN(arstN), .dispatchValid(dispatchValid),
        .dispatchOp(dispatchOp), .dispatchTag(dispatchTag),
        .dispatchA(dispatchA), .dispatchB(dispatchB),
        .dispatchUseImm(dispatchUseImm), .dispatchImm(dispatchImm),
        .dispatchShamt(dispatchShamt), .dispatchShType(dispatchShType),
        .cdbValid(cdbValid), .cdbTag(cdbTag), .cdbData(cdbData)
    );

endmodule

`default_nettype wire

/* design/executeUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module executeUnit import armCorePkg::*; (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   dispatchValid,
    input  logic [3:0]             dispatchOp,
    input  logic [robTagWidth-1:0] dispatchTag,
    input  logic [dataWidth-1:0]   dispatchA,
    input  logic [dataWidth-1:0]   dispatchB,
    input  logic                   dispatchUseImm,
    input  logic [dataWidth-1:0]   dispatchImm,
    input  logic [4:0]             dispatchShamt,
    input  logic [1:0]             dispatchShType,
    output logic                   cdbValid,
    output logic [robTagWidth-1:0] cdbTag,
    output logic [dataWidth-1:0]   cdbData
);

    logic                   exValid;
    logic [3:0]             exOp;
    logic [robTagWidth-1:0] exTag;
    logic [dataWidth-1:0]   exA, exB, exImm;
    logic                   exUseImm;
    logic [4:0]             exShamt;
    logic [1:0]             exShType;
    logic [dataWidth-1:0]   shOut, op2, aluOut;
    logic [2*dataWidth-1:0] rorPair;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exValid  <= 1'b0;
            cdbValid <= 1'b0;
        end else begin
            exValid  <= dispatchValid;
            cdbValid <= exValid;
        end
    end

    always_ff @(posedge clk) begin
        exOp     <= dispatchOp;
        exTag    <= dispatchTag;
        exA      <= dispatchA;
        exB      <= dispatchB;
        exUseImm <= dispatchUseImm;
        exImm    <= dispatchImm;
        exShamt  <= dispatchShamt;
        exShType <= dispatchShType;
        cdbTag   <= exTag;
        cdbData  <= aluOut;
    end

    //////////////////////////////////////////////////////////////////////
    // Shifter
    // LSR and ASR by 0 encode a shift by 32
    assign rorPair = {exB, exB} >> exShamt;

    always_comb begin
        case (exShType)
            shLsl:   shOut = exB << exShamt;
            shLsr:   shOut = (exShamt == '0) ? '0 : exB >> exShamt;
            shAsr: begin
                if (exShamt == '0) begin
                    shOut = {dataWidth{exB[dataWidth-1]}};
                end else begin
                    shOut = $signed(exB) >>> exShamt;
                end
            end
            default: shOut = rorPair[dataWidth-1:0];
        endcase
    end

    assign op2 = exUseImm ? exImm : shOut;

    //////////////////////////////////////////////////////////////////////
    // ALU
    always_comb begin
        case (exOp)
            opAnd:   aluOut = exA & op2;
            opEor:   aluOut = exA ^ op2;
            opSub:   aluOut = exA - op2;
            opRsb:   aluOut = op2 - exA;
            opAdd:   aluOut = exA + op2;
            opOrr:   aluOut = exA | op2;
            opBic:   aluOut = exA & ~op2;
            opMvn:   aluOut = ~op2;
            default: aluOut = op2;
        endcase
    end

endmodule

`default_nettype wire

/* design/reservationStation.sv */
`timescale 1ns/100ps
`default_nettype none

module reservationStation import armCorePkg::*; (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   issue,
    input  logic [3:0]             op,
    input  logic [robTagWidth-1:0] robTag,
    input  logic                   srcAReady,
    input  logic [dataWidth-1:0]   srcAValue,
    input  logic [robTagWidth-1:0] srcATag,
    input  logic                   srcBReady,
    input  logic [dataWidth-1:0]   srcBValue,
    input  logic [robTagWidth-1:0] srcBTag,
    input  logic                   useImm,
    input  logic [dataWidth-1:0]   imm,
    input  logic [4:0]             shamt,
    input  logic [1:0]             shType,
    output logic                   full,
    input  logic                   cdbValid,
    input  logic [robTagWidth-1:0] cdbTag,
    input  logic [dataWidth-1:0]   cdbData,
    output logic                   dispatchValid,
    output logic [3:0]             dispatchOp,
    output logic [robTagWidth-1:0] dispatchTag,
    output logic [dataWidth-1:0]   dispatchA,
    output logic [dataWidth-1:0]   dispatchB,
    output logic                   dispatchUseImm,
    output logic [dataWidth-1:0]   dispatchImm,
    output logic [4:0]             dispatchShamt,
    output logic [1:0]             dispatchShType
);

    logic [rsDepth-1:0]     busy, aReady, bReady, ready, isOldest;
    // olderThan[i][j] set when entry j entered before entry i
    logic [rsDepth-1:0]     olderThan [rsDepth];
    logic [3:0]             eOp     [rsDepth];
    logic [robTagWidth-1:0] eTag    [rsDepth];
    logic [robTagWidth-1:0] aTag    [rsDepth];
    logic [robTagWidth-1:0] bTag    [rsDepth];
    logic [dataWidth-1:0]   aVal    [rsDepth];
    logic [dataWidth-1:0]   bVal    [rsDepth];
    logic [dataWidth-1:0]   eImm    [rsDepth];
    logic                   eUseImm [rsDepth];
    logic [4:0]             eShamt  [rsDepth];
    logic [1:0]             eShType [rsDepth];
    logic [rsIdxWidth-1:0]  freeSlot, pick;

    assign full  = &busy;
    assign ready = busy & aReady & bReady;

    always_comb begin
        freeSlot = '0;
        pick     = '0;
        for (int i = rsDepth - 1; i >= 0; i--) begin
            isOldest[i] = ready[i] && !(|(ready & olderThan[i]));
            if (!busy[i]) freeSlot = rsIdxWidth'(i);
            if (isOldest[i]) pick = rsIdxWidth'(i);
        end
    end

    assign dispatchValid  = |ready;
    assign dispatchOp     = eOp[pick];
    assign dispatchTag    = eTag[pick];
    assign dispatchA      = aVal[pick];
    assign dispatchB      = bVal[pick];
    assign dispatchUseImm = eUseImm[pick];
    assign dispatchImm    = eImm[pick];
    assign dispatchShamt  = eShamt[pick];
    assign dispatchShType = eShType[pick];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            busy      <= '0;
            aReady    <= '0;
            bReady    <= '0;
            olderThan <= '{default: '0};
        end else begin
            for (int i = 0; i < rsDepth; i++) begin
                if (cdbValid && aTag[i] == cdbTag) aReady[i] <= 1'b1;
                if (cdbValid && bTag[i] == cdbTag) bReady[i] <= 1'b1;
                if (issue) olderThan[i][freeSlot] <= 1'b0;
            end
            if (dispatchValid) begin
                busy[pick] <= 1'b0;
            end
            if (issue) begin
                busy[freeSlot]      <= 1'b1;
                aReady[freeSlot]    <= srcAReady;
                bReady[freeSlot]    <= srcBReady;
                olderThan[freeSlot] <= busy;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < rsDepth; i++) begin
            if (cdbValid && !aReady[i] && aTag[i] == cdbTag) aVal[i] <= cdbData;
            if (cdbValid && !bReady[i] && bTag[i] == cdbTag) bVal[i] <= cdbData;
        end
        if (issue) begin
            eOp[freeSlot]     <= op;
            eTag[freeSlot]    <= robTag;
            aVal[freeSlot]    <= srcAValue;
            aTag[freeSlot]    <= srcATag;
            bVal[freeSlot]    <= srcBValue;
            bTag[freeSlot]    <= srcBTag;
            eUseImm[freeSlot] <= useImm;
            eImm[freeSlot]    <= imm;
            eShamt[freeSlot]  <= shamt;
            eShType[freeSlot] <= shType;
        end
    end

    noIssueWhenFull: assert property (@(posedge clk) disable iff (!arstN)
        issue |-> !full);

endmodule

`default_nettype wire

/* design/reorderBuffer.sv */
`timescale 1ns/100ps
`default_nettype none

module reorderBuffer import armCorePkg::*; (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    issue,
    input  logic [regAddrWidth-1:0] issueReg,
    output logic [robTagWidth-1:0]  tail,
    output logic                    full,
    input  logic [robTagWidth-1:0]  queryATag,
    output logic                    queryADone,
    output logic [dataWidth-1:0]    queryAData,
    input  logic [robTagWidth-1:0]  queryBTag,
    output logic                    queryBDone,
    output logic [dataWidth-1:0]    queryBData,
    input  logic                    cdbValid,
    input  logic [robTagWidth-1:0]  cdbTag,
    input  logic [dataWidth-1:0]    cdbData,
    output logic                    commitValid,
    output logic [regAddrWidth-1:0] commitReg,
    output logic [dataWidth-1:0]    commitData,
    output logic [robTagWidth-1:0]  commitTag
);

    logic [regAddrWidth-1:0] entryReg  [robDepth];
    logic [dataWidth-1:0]    entryData [robDepth];
    logic [robDepth-1:0]     entryDone;
    logic [robTagWidth-1:0]  head;
    logic [robTagWidth:0]    count;

    assign full = (count == (robTagWidth+1)'(robDepth));

    assign queryADone = entryDone[queryATag];
    assign queryAData = entryData[queryATag];
    assign queryBDone = entryDone[queryBTag];
    assign queryBData = entryData[queryBTag];

    // Retire the head once its result is back
    assign commitValid = (count != '0) && entryDone[head];
    assign commitReg   = entryReg[head];
    assign commitData  = entryData[head];
    assign commitTag   = head;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            entryDone <= '0;
        end else begin
            if (issue) begin
                entryDone[tail] <= 1'b0;
                tail            <= tail + 1'b1;
            end
            if (cdbValid) begin
                entryDone[cdbTag] <= 1'b1;
            end
            if (commitValid) begin
                head <= head + 1'b1;
            end
            count <= count + {{robTagWidth{1'b0}}, issue} - {{robTagWidth{1'b0}}, commitValid};
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            entryReg[tail] <= issueReg;
        end
        if (cdbValid) begin
            entryData[cdbTag] <= cdbData;
        end
    end

    noIssueWhenFull: assert property (@(posedge clk) disable iff (!arstN)
        issue |-> !full);

    cdbTagInFlight: assert property (@(posedge clk) disable iff (!arstN)
        cdbValid |-> ({1'b0, robTagWidth'(cdbTag - head)} < count));

endmodule

`default_nettype wire

/* design/registerStatusFile.sv */
`timescale 1ns/100ps
`default_nettype none

module registerStatusFile import armCorePkg::*; (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic [regAddrWidth-1:0] rn,
    input  logic [regAddrWidth-1:0] rm,
    output logic [dataWidth-1:0]    srcAValue,
    output logic                    srcABusy,
    output logic [robTagWidth-1:0]  srcATag,
    output logic [dataWidth-1:0]    srcBValue,
    output logic                    srcBBusy,
    output logic [robTagWidth-1:0]  srcBTag,
    input  logic                    issue,
    input  logic [regAddrWidth-1:0] rd,
    input  logic [robTagWidth-1:0]  issueTag,
    input  logic                    commitValid,
    input  logic [regAddrWidth-1:0] commitReg,
    input  logic [dataWidth-1:0]    commitData,
    input  logic [robTagWidth-1:0]  commitTag
);

    logic [dataWidth-1:0]   regs [16];
    logic [robTagWidth-1:0] tags [16];
    logic [15:0]            busy;

    assign srcAValue = regs[rn];
    assign srcABusy  = busy[rn];
    assign srcATag   = tags[rn];
    assign srcBValue = regs[rm];
    assign srcBBusy  = busy[rm];
    assign srcBTag   = tags[rm];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regs <= '{default: '0};
            tags <= '{default: '0};
            busy <= '0;
        end else begin
            if (commitValid) begin
                regs[commitReg] <= commitData;
                // Only the latest writer frees the register
                if (tags[commitReg] == commitTag) begin
                    busy[commitReg] <= 1'b0;
                end
            end
            if (issue) begin
                busy[rd] <= 1'b1;
                tags[rd] <= issueTag;
            end
        end
    end

    commitOnBusyReg: assert property (@(posedge clk) disable iff (!arstN)
        commitValid |-> busy[commitReg]);

endmodule

`default_nettype wire

/* design/decodeStage.sv */
`timescale 1ns/100ps
`default_nettype none

module decodeStage import armCorePkg::*; (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    stall,
    output logic [dataWidth-1:0]    pc,
    input  logic [dataWidth-1:0]    instr,
    output logic                    issueValid,
    output logic [3:0]              op,
    output logic [regAddrWidth-1:0] rn,
    output logic [regAddrWidth-1:0] rm,
    output logic [regAddrWidth-1:0] rd,
    output logic                    useImm,
    output logic [dataWidth-1:0]    imm,
    output logic [4:0]              shamt,
    output logic [1:0]              shType
);

    instrWordT instrD;
    logic      validD;
    logic      opSupported;
    logic [2*dataWidth-1:0] immPair;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc     <= '0;
            validD <= 1'b0;
        end else if (!stall) begin
            pc     <= pc + 32'd4;
            validD <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            instrD <= instr;
        end
    end

    assign opSupported = instrD.immView.opcode inside
        {opAnd, opEor, opSub, opRsb, opAdd, opOrr, opMov, opBic, opMvn};

    // Only class 00 words issue; register-specified shifts are not handled
    assign issueValid = validD && (instrD.immView.cls == 2'b00) && opSupported
                        && (instrD.immView.iBit || !instrD.regView.regShift);

    assign op     = instrD.immView.opcode;
    assign rn     = instrD.immView.rn;
    assign rd     = instrD.immView.rd;
    assign useImm = instrD.immView.iBit;
    assign rm     = instrD.regView.rm;
    assign shamt  = instrD.regView.shamt5;
    assign shType = instrD.regView.shType;

    // imm8 rotated right by twice the rotate field
    assign immPair = {2{24'd0, instrD.immView.imm8}} >> {instrD.immView.rotate, 1'b0};
    assign imm     = immPair[dataWidth-1:0];

endmodule

`default_nettype wire

/* design/armCorePkg.sv */
`default_nettype none

package armCorePkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 4;
    localparam int robDepth     = 8;
    localparam int robTagWidth  = 3;
    localparam int rsDepth      = 4;
    localparam int rsIdxWidth   = 2;

    // ARM data-processing opcodes
    localparam logic [3:0] opAnd = 4'b0000;
    localparam logic [3:0] opEor = 4'b0001;
    localparam logic [3:0] opSub = 4'b0010;
    localparam logic [3:0] opRsb = 4'b0011;
    localparam logic [3:0] opAdd = 4'b0100;
    localparam logic [3:0] opOrr = 4'b1100;
    localparam logic [3:0] opMov = 4'b1101;
    localparam logic [3:0] opBic = 4'b1110;
    localparam logic [3:0] opMvn = 4'b1111;

    localparam logic [1:0] shLsl = 2'b00;
    localparam logic [1:0] shLsr = 2'b01;
    localparam logic [1:0] shAsr = 2'b10;
    localparam logic [1:0] shRor = 2'b11;

    // Operand 2 is read either as rotated imm8 or as a shifted Rm
    typedef union packed {
        struct packed {
            logic [3:0] cond;
            logic [1:0] cls;
            logic       iBit;
            logic [3:0] opcode;
            logic       sBit;
            logic [3:0] rn;
            logic [3:0] rd;
            logic [3:0] rotate;
            logic [7:0] imm8;
        } immView;
        struct packed {
            logic [3:0] cond;
            logic [1:0] cls;
            logic       iBit;
            logic [3:0] opcode;
            logic       sBit;
            logic [3:0] rn;
            logic [3:0] rd;
            logic [4:0] shamt5;
            logic [1:0] shType;
            logic       regShift;
            logic [3:0] rm;
        } regView;
    } instrWordT;

endpackage

`default_nettype wire
